/* rv_isa_pkg.sv */
// RV32I instruction set definitions
package rv_isa_pkg;

    // Data path width.
    localparam int xlen = 32;
    // Instruction field widths.
    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int reg_addr_w = 5;
    // Architectural register count, x0 included.
    localparam int reg_count = 32;

    // Data word, also used for addresses and instruction words.
    typedef logic [xlen-1:0] word_t;
    // Register number.
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    // Minor opcode field.
    typedef logic [funct3_w-1:0] funct3_t;

    // Major opcodes handled by the core.
    typedef enum logic [opcode_w-1:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    // ALU operations, funct3 of OP and OP-IMM.
    typedef enum logic [funct3_w-1:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_sr   = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_funct_e;

    // Branch compares, funct3 of BRANCH.
    typedef enum logic [funct3_w-1:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_funct_e;

    // Access size, low two bits of load and store funct3.
    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } mem_size_e;

endpackage

/* core_pipe_pkg.sv */
// Pipeline record types
package core_pipe_pkg;
    import rv_isa_pkg::*;

    // PC after reset.
    localparam word_t entry_pc = '0;
    // Instruction size in bytes, no compressed forms.
    localparam word_t insn_step = 32'd4;

    // Fetch/decode record.
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t insn;
    } fetch_rec_t;

    // Decode/execute record.
    typedef struct packed {
        logic      valid;
        opcode_e   op;
        funct3_t   funct3;
        // Selects sub and sra.
        logic      alt;
        // Zero when nothing is written.
        reg_addr_t rd;
        word_t     lhs;
        word_t     rhs;
        word_t     store_data;
        // Load and store offset.
        word_t     offset;
        logic      predicted_taken;
        // PC of the path not predicted.
        word_t     alt_pc;
    } exec_rec_t;

    // PC redirect request.
    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // Register write-back.
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } writeback_t;

endpackage

/* fetch_stage.sv */
// Instruction fetch stage
`timescale 1ns/1ps

module fetch_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_latch,
    input  logic       stall,
    input  redirect_t  predict,
    input  redirect_t  correct,
    input  word_t      prog_data,
    output word_t      prog_addr,
    output logic       prog_re,
    output fetch_rec_t fetch_out
);

    word_t pc;
    word_t next_pc;

    // Correction beats prediction.
    always_comb begin
        if (correct.valid) begin
            next_pc = correct.target;
        end else if (predict.valid) begin
            next_pc = predict.target;
        end else begin
            next_pc = pc + insn_step;
        end
    end

    // Program bus, read answers in the same cycle.
    assign prog_addr = pc;
    assign prog_re = !stall;

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            pc <= entry_pc;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

    // Fetch/decode register.
    // A redirect kills the word fetched this cycle.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            fetch_out.valid <= 1'b0;
        end else if (!stall) begin
            fetch_out.valid <= !(predict.valid || correct.valid);
            fetch_out.pc <= pc;
            fetch_out.insn <= prog_data;
        end
    end

    // Targets come from word-aligned offsets only.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst_latch) pc[1:0] == 2'b00)
        else $error("fetch PC not word aligned: %h", pc);

endmodule

/* reg_file.sv */
// General register file
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_latch,
    input  logic       stall,
    input  writeback_t wb,
    input  reg_addr_t  rs1,
    input  reg_addr_t  rs2,
    output word_t      rs1_val,
    output word_t      rs2_val
);

    // x1 to x31, x0 has no storage.
    word_t regs [1:reg_count-1];

    // Write on the edge that ends execute.
    always_ff @(posedge clk) begin
        if (wb.valid && !stall && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Reads are combinational.
    // x0 reads as zero.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // Execute must already drop writes to x0.
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst_latch)
        wb.valid |-> wb.rd != '0)
        else $error("write-back aimed at x0");

endmodule

/* decode_stage.sv */
// Instruction decode stage
`timescale 1ns/1ps

module decode_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_latch,
    input  logic       stall,
    input  fetch_rec_t fetch_in,
    input  redirect_t  correct,
    input  writeback_t wb,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output redirect_t  predict,
    output exec_rec_t  exec_out
);

    word_t     insn;
    opcode_e   op;
    logic      known;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     imm_u;
    word_t     imm_j;
    word_t     src1;
    word_t     src2;
    word_t     branch_target;
    word_t     jal_target;
    logic      is_jal;
    logic      is_branch;
    logic      back_branch;
    exec_rec_t dec;

    assign insn = fetch_in.insn;
    assign op = opcode_e'(insn[6:0]);
    assign rs1 = insn[19:15];
    assign rs2 = insn[24:20];

    // Anything else leaves as a bubble.
    always_comb begin
        case (op)
            opc_lui, opc_auipc, opc_jal, opc_branch,
            opc_load, opc_store, opc_op_imm, opc_op: begin
                known = 1'b1;
            end
            default: begin
                known = 1'b0;
            end
        endcase
    end

    // Immediates.
    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    // Result of the instruction in execute, not yet in the register file.
    assign src1 = (wb.valid && wb.rd == rs1) ? wb.data : rs1_val;
    assign src2 = (wb.valid && wb.rd == rs2) ? wb.data : rs2_val;

    // Jump and branch targets.
    assign branch_target = fetch_in.pc + imm_b;
    assign jal_target = fetch_in.pc + imm_j;

    // Static prediction, backward branches taken.
    assign is_jal = fetch_in.valid && op == opc_jal;
    assign is_branch = fetch_in.valid && op == opc_branch;
    assign back_branch = imm_b[xlen-1];
    // Nothing here survives a correction.
    assign predict = '{
        valid: !correct.valid && (is_jal || (is_branch && back_branch)),
        target: is_jal ? jal_target : branch_target
    };

    // Operand selection.
    always_comb begin
        dec.valid = fetch_in.valid && known && !correct.valid;
        dec.op = op;
        dec.funct3 = insn[14:12];
        dec.alt = 1'b0;
        dec.rd = insn[11:7];
        dec.lhs = src1;
        dec.rhs = src2;
        dec.store_data = src2;
        dec.offset = imm_i;
        dec.predicted_taken = back_branch;
        // Fall-through when taken is guessed, target otherwise.
        dec.alt_pc = back_branch ? fetch_in.pc + insn_step : branch_target;
        case (op)
            opc_lui: begin
                dec.lhs = '0;
                dec.rhs = imm_u;
                dec.funct3 = alu_add;
            end
            opc_auipc: begin
                dec.lhs = fetch_in.pc;
                dec.rhs = imm_u;
                dec.funct3 = alu_add;
            end
            opc_jal: begin
                // Link value pc + 4.
                dec.lhs = fetch_in.pc;
                dec.rhs = insn_step;
                dec.funct3 = alu_add;
            end
            opc_branch: begin
                dec.rd = '0;
            end
            opc_store: begin
                dec.rd = '0;
                dec.offset = imm_s;
            end
            opc_op_imm: begin
                // insn[30] only matters for srai here
                dec.rhs = imm_i;
                dec.alt = insn[30];
            end
            opc_op: begin
                dec.alt = insn[30];
            end
            default: begin
                // Loads and bubbles take the defaults.
            end
        endcase
    end

    // Decode/execute register.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            exec_out.valid <= 1'b0;
        end else if (!stall) begin
            exec_out <= dec;
        end
    end

endmodule

/* alu_rv32i.sv */
// RV32I integer ALU
`timescale 1ns/1ps

module alu_rv32i import rv_isa_pkg::*; (
    input  funct3_t funct3,
    input  logic    alt,
    input  logic    is_op_imm,
    input  logic    is_branch,
    input  word_t   lhs,
    input  word_t   rhs,
    output word_t   result,
    output logic    taken
);

    logic [$clog2(xlen)-1:0] shamt;
    logic  eq;
    logic  lt;
    logic  ltu;

    assign shamt = rhs[$clog2(xlen)-1:0];
    assign eq = lhs == rhs;
    assign lt = $signed(lhs) < $signed(rhs);
    assign ltu = lhs < rhs;

    // Arithmetic and logic.
    always_comb begin
        case (alu_funct_e'(funct3))
            // addi has no subtract form.
            alu_add:  result = (alt && !is_op_imm) ? lhs - rhs : lhs + rhs;
            alu_sll:  result = lhs << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt};
            alu_sltu: result = {{(xlen-1){1'b0}}, ltu};
            alu_xor:  result = lhs ^ rhs;
            alu_sr:   result = alt ? word_t'($signed(lhs) >>> shamt) : lhs >> shamt;
            alu_or:   result = lhs | rhs;
            default:  result = lhs & rhs;
        endcase
    end

    // Branch condition.
    always_comb begin
        taken = 1'b0;
        if (is_branch) begin
            case (branch_funct_e'(funct3))
                br_beq:  taken = eq;
                br_bne:  taken = !eq;
                br_blt:  taken = lt;
                br_bge:  taken = !lt;
                br_bltu: taken = ltu;
                br_bgeu: taken = !ltu;
                default: taken = 1'b0;
            endcase
        end
    end

endmodule

/* execute_stage.sv */
// Execute and memory stage
`timescale 1ns/1ps

module execute_stage import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rst_latch,
    input  exec_rec_t  exec_in,
    input  word_t      mem_rdata,
    input  logic       mem_ready,
    output logic       mem_re,
    output logic       mem_we,
    output mem_size_e  mem_size,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output logic       stall,
    output redirect_t  correct,
    output writeback_t wb
);

    word_t alu_result;
    logic  taken;
    logic  is_branch;
    logic  is_load;
    logic  sext;
    word_t load_val;

    assign is_branch = exec_in.op == opc_branch;
    assign is_load = exec_in.op == opc_load;

    alu_rv32i alu_inst (
        .funct3    (exec_in.funct3),
        .alt       (exec_in.alt),
        .is_op_imm (exec_in.op == opc_op_imm),
        .is_branch (is_branch),
        .lhs       (exec_in.lhs),
        .rhs       (exec_in.rhs),
        .result    (alu_result),
        .taken     (taken)
    );

    // Data bus request.
    // Data is right justified, lane steering sits in the memory.
    assign mem_re = exec_in.valid && is_load;
    assign mem_we = exec_in.valid && exec_in.op == opc_store;
    assign mem_size = mem_size_e'(exec_in.funct3[1:0]);
    assign mem_addr = exec_in.lhs + exec_in.offset;
    assign mem_wdata = exec_in.store_data;

    // Freeze the pipeline until the access completes.
    assign stall = (mem_re || mem_we) && !mem_ready;

    // funct3[2] marks the unsigned loads.
    assign sext = !exec_in.funct3[2];

    // Load extension.
    always_comb begin
        case (mem_size)
            sz_byte: load_val = {{(xlen-8){sext && mem_rdata[7]}}, mem_rdata[7:0]};
            sz_half: load_val = {{(xlen-16){sext && mem_rdata[15]}}, mem_rdata[15:0]};
            default: load_val = mem_rdata;
        endcase
    end

    // Mispredicted branch, resume on the other path.
    assign correct = '{
        valid: exec_in.valid && is_branch && taken != exec_in.predicted_taken,
        target: exec_in.alt_pc
    };

    // Retire.
    assign wb = '{
        valid: exec_in.valid && !stall && exec_in.rd != '0,
        rd: exec_in.rd,
        data: is_load ? load_val : alu_result
    };

    a_re_we_excl: assert property (@(posedge clk) disable iff (rst_latch)
        !(mem_re && mem_we))
        else $error("load and store requested together");

    // Decode/execute must hold while the bus is not ready.
    a_req_stable: assert property (@(posedge clk) disable iff (rst_latch)
        stall |=> $stable({mem_re, mem_we, mem_size, mem_addr, mem_wdata}))
        else $error("data bus request changed while stalled");

endmodule

/* rv32i_core.sv */
// RV32I three-stage core
`timescale 1ns/1ps

module rv32i_core import rv_isa_pkg::*, core_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_latch,
    // Program bus.
    output word_t     prog_addr,
    output logic      prog_re,
    input  word_t     prog_data,
    // Data bus.
    output logic      mem_re,
    output logic      mem_we,
    output mem_size_e mem_size,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    input  word_t     mem_rdata,
    input  logic      mem_ready
);

    fetch_rec_t fetch_rec;
    exec_rec_t  exec_rec;
    redirect_t  predict;
    redirect_t  correct;
    writeback_t wb;
    logic       stall;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_val;
    word_t      rs2_val;

    fetch_stage fetch_inst (
        .clk       (clk),
        .rst_latch (rst_latch),
        .stall     (stall),
        .predict   (predict),
        .correct   (correct),
        .prog_data (prog_data),
        .prog_addr (prog_addr),
        .prog_re   (prog_re),
        .fetch_out (fetch_rec)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst_latch (rst_latch),
        .stall     (stall),
        .wb        (wb),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val)
    );

    decode_stage decode_inst (
        .clk       (clk),
        .rst_latch (rst_latch),
        .stall     (stall),
        .fetch_in  (fetch_rec),
        .correct   (correct),
        .wb        (wb),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val),
        .rs1       (rs1),
        .rs2       (rs2),
        .predict   (predict),
        .exec_out  (exec_rec)
    );

    execute_stage execute_inst (
        .clk       (clk),
        .rst_latch (rst_latch),
        .exec_in   (exec_rec),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_size  (mem_size),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .stall     (stall),
        .correct   (correct),
        .wb        (wb)
    );

endmodule

/* tb_program.svh */
// Core test program
`ifndef tb_program_svh
`define tb_program_svh

// Words in the program, halt loop included.
localparam int prog_len = 44;
// Trips through the backward loop.
localparam int loop_count = 3;
// Negative bytes and halves for the load tests.
localparam word_t data_word0 = 32'hF0E1_8283;
localparam word_t nop_word = 32'h0000_0013;

// One expected store.
typedef struct packed {
    word_t addr;
    word_t data;
} store_rec_t;

word_t rom [0:63];
int rom_fill = 0;
store_rec_t exp_store [0:15];
string exp_name [0:15];
int exp_total = 0;

function automatic word_t r_type(logic [2:0] f3, int rd, int rs1, int rs2, logic alt);
    return {1'b0, alt, 5'b00000, rs2[4:0], rs1[4:0], f3, rd[4:0], opc_op};
endfunction

function automatic word_t i_type(opcode_e opc, logic [2:0] f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
endfunction

function automatic word_t store_word(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opc_store};
endfunction

function automatic word_t b_type(logic [2:0] f3, int rs1, int rs2, int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic word_t u_type(opcode_e opc, int rd, int imm20);
    return {imm20[19:0], rd[4:0], opc};
endfunction

function automatic word_t j_type(int rd, int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc_jal};
endfunction

task automatic emit(word_t insn);
    rom[rom_fill] = insn;
    rom_fill++;
endtask

task automatic expect_store(word_t store_addr, word_t store_data, string name);
    exp_store[exp_total] = '{addr: store_addr, data: store_data};
    exp_name[exp_total] = name;
    exp_total++;
endtask

task automatic load_program();
    // ALU chain, every result feeds the next instruction.
    emit(i_type(opc_op_imm, alu_add, 10, 0, 32'h80));
    emit(i_type(opc_op_imm, alu_add, 1, 0, 5));
    emit(i_type(opc_op_imm, alu_add, 2, 1, -12));
    emit(r_type(alu_add, 3, 1, 2, 1'b1));
    emit(store_word(3, 10, 0));
    // srai by 1, then srli by 28.
    emit(i_type(opc_op_imm, alu_sr, 4, 2, 32'h401));
    emit(i_type(opc_op_imm, alu_sr, 5, 4, 28));
    emit(r_type(alu_xor, 6, 5, 4, 1'b0));
    emit(store_word(6, 10, 4));
    emit(r_type(alu_slt, 7, 2, 1, 1'b0));
    emit(r_type(alu_sltu, 8, 1, 2, 1'b0));
    emit(i_type(opc_op_imm, alu_sll, 9, 7, 4));
    emit(r_type(alu_or, 9, 9, 8, 1'b0));
    emit(store_word(9, 10, 8));
    emit(u_type(opc_lui, 11, 32'hABCDE));
    emit(i_type(opc_op_imm, alu_add, 11, 11, 32'h123));
    emit(store_word(11, 10, 12));
    emit(u_type(opc_auipc, 12, 1));  // At 0x44.
    emit(store_word(12, 10, 16));
    // Backward loop adds 7 per trip.
    emit(i_type(opc_op_imm, alu_add, 16, 0, 0));
    emit(i_type(opc_op_imm, alu_add, 17, 0, loop_count));
    emit(i_type(opc_op_imm, alu_add, 16, 16, 7));
    emit(i_type(opc_op_imm, alu_add, 17, 17, -1));
    emit(b_type(br_bne, 17, 0, -8));
    emit(store_word(16, 10, 20));
    // Forward branches, then a JAL with a link.
    emit(b_type(br_beq, 1, 2, 8));
    emit(store_word(1, 10, 24));
    emit(b_type(br_bne, 1, 2, 12));
    // Shadow stores, never retired.
    emit(store_word(2, 10, 64));
    emit(store_word(2, 10, 68));
    emit(j_type(18, 8));
    emit(store_word(2, 10, 72));
    emit(store_word(18, 10, 28));
    // Loads of word 0, each stored back.
    emit(i_type(opc_load, 3'b000, 19, 0, 0));
    emit(store_word(19, 10, 32));
    emit(i_type(opc_load, 3'b100, 20, 0, 1));
    emit(store_word(20, 10, 36));
    emit(i_type(opc_load, 3'b001, 21, 0, 2));
    emit(store_word(21, 10, 40));
    emit(i_type(opc_load, 3'b101, 22, 0, 0));
    emit(store_word(22, 10, 44));
    emit(i_type(opc_load, 3'b010, 23, 0, 0));
    emit(store_word(23, 10, 48));
    // Halt on a jump to itself.
    emit(j_type(0, 0));

    expect_store(32'h80, 32'h0000_000C, "sub_forward");
    expect_store(32'h84, 32'hFFFF_FFF3, "shift_xor");
    expect_store(32'h88, 32'h0000_0011, "slt_sltu_or");
    expect_store(32'h8C, 32'hABCD_E123, "lui_addi");
    expect_store(32'h90, 32'h0000_1044, "auipc");
    expect_store(32'h94, word_t'(7 * loop_count), "loop_sum");
    expect_store(32'h98, 32'h0000_0005, "beq_not_taken");
    expect_store(32'h9C, 32'h0000_007C, "jal_link");
    expect_store(32'hA0, 32'hFFFF_FF83, "lb");
    expect_store(32'hA4, 32'h0000_0082, "lbu");
    expect_store(32'hA8, 32'hFFFF_F0E1, "lh");
    expect_store(32'hAC, 32'h0000_8283, "lhu");
    expect_store(32'hB0, 32'hF0E1_8283, "lw");
endtask

`endif

/* tb_rv32i_core.sv */
// RV32I core testbench
`timescale 1ns/1ps

module tb_rv32i_core import rv_isa_pkg::*, core_pipe_pkg::*; ();

    logic      clk;
    logic      rst_latch;
    word_t     prog_addr;
    logic      prog_re;
    word_t     prog_data;
    logic      mem_re;
    logic      mem_we;
    mem_size_e mem_size;
    word_t     mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;
    logic      mem_ready;
    word_t     dmem [0:63];
    integer    seed = 60;
    int        cycle = 0;
    int        store_idx = 0;
    int        value_errors = 0;
    int        protocol_errors = 0;
    logic      rst_q;

    `include "tb_program.svh"

    // Room for every loop trip plus reset and bus waits.
    localparam int timeout_limit = prog_len * loop_count * 4 + 200;

    rv32i_core rv32i_core_inst (
        .clk       (clk),
        .rst_latch (rst_latch),
        .prog_addr (prog_addr),
        .prog_re   (prog_re),
        .prog_data (prog_data),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_size  (mem_size),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Program ROM. Words past the program read as nop.
    assign prog_data = ((prog_addr >> 2) < word_t'(rom_fill)) ? rom[prog_addr[7:2]] : nop_word;

    // Data RAM read, right justified.
    assign mem_rdata = dmem[mem_addr[7:2]] >> {mem_addr[1:0], 3'b000};

    // Ready is high about three cycles in four.
    always @(posedge clk) begin
        #1;
        mem_ready = ($random(seed) % 4) != 0;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Completed stores go to RAM and are checked in order.
    always @(posedge clk) begin
        rst_q <= rst_latch;
        if (!rst_latch && mem_we && mem_ready) begin
            case (mem_size)
                sz_byte: dmem[mem_addr[7:2]][{mem_addr[1:0], 3'b000} +: 8] <= mem_wdata[7:0];
                sz_half: dmem[mem_addr[7:2]][{mem_addr[1], 4'b0000} +: 16] <= mem_wdata[15:0];
                default: dmem[mem_addr[7:2]] <= mem_wdata;
            endcase
            a_store_in_sequence: assert (store_idx < exp_total)
                else begin
                    protocol_errors++;
                    $display("store to %h after the expected sequence ended", mem_addr);
                end
            if (store_idx < exp_total) begin
                a_store_addr: assert (mem_addr == exp_store[store_idx].addr)
                    else begin
                        value_errors++;
                        $display("[ERROR] %s addr: expected %h, actual %h",
                            exp_name[store_idx], exp_store[store_idx].addr, mem_addr);
                    end
                a_store_data: assert (mem_wdata == exp_store[store_idx].data)
                    else begin
                        value_errors++;
                        $display("[ERROR] %s data: expected %h, actual %h",
                            exp_name[store_idx], exp_store[store_idx].data, mem_wdata);
                    end
                // Every store in the program is sw.
                a_store_size: assert (mem_size == sz_word)
                    else begin
                        value_errors++;
                        $display("[ERROR] %s size: expected %0d, actual %0d",
                            exp_name[store_idx], sz_word, mem_size);
                    end
            end
            store_idx <= store_idx + 1;
        end
    end

    // PC and bus idle during reset and one cycle after.
    always @(negedge clk) begin
        if (rst_latch || rst_q) begin
            a_reset_pc: assert (prog_addr == entry_pc)
                else begin
                    value_errors++;
                    $display("[ERROR] reset_pc: expected %h, actual %h", entry_pc, prog_addr);
                end
            a_reset_bus: assert (!mem_re && !mem_we)
                else begin
                    protocol_errors++;
                    $display("data bus request seen during reset");
                end
        end
    end

    a_bus_hold: assert property (@(posedge clk) disable iff (rst_latch)
        (mem_re || mem_we) && !mem_ready |=> $stable({mem_re, mem_we, mem_addr, mem_wdata}))
        else begin
            protocol_errors++;
            $display("data bus request changed while mem_ready was low");
        end

    // Fetch pauses exactly while a data access waits for mem_ready.
    a_fetch_pause: assert property (@(posedge clk) disable iff (rst_latch)
        prog_re == !((mem_re || mem_we) && !mem_ready))
        else begin
            protocol_errors++;
            $display("prog_re does not follow the data bus wait");
        end

    initial begin
        int i;
        rst_latch = 1'b1;
        mem_ready = 1'b0;
        load_program();
        for (i = 0; i < 64; i++) begin
            dmem[i] = 32'h1000_0000 + i * 32'h0001_0001;
        end
        dmem[0] = data_word0;
        repeat (8) @(posedge clk);
        #1;
        rst_latch = 1'b0;
        while (store_idx < exp_total && cycle < timeout_limit) begin
            @(posedge clk);
        end
        if (store_idx < exp_total) begin
            protocol_errors++;
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                cycle, store_idx, exp_total);
        end else begin
            // Halt loop runs on, stray stores would show here.
            repeat (10) @(posedge clk);
        end
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
rv_isa_pkg.sv
core_pipe_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
alu_rv32i.sv
execute_stage.sv
rv32i_core.sv
tb_rv32i_core.sv
